// ==== csi2_pkg.sv ====
`default_nettype none

package csi2_pkg;

  // Stream and header geometry
  localparam int WORD_W     = 32;
  localparam int BYTE_W     = 8;
  localparam int WORD_BYTES = WORD_W / BYTE_W;
  localparam int ECC_W      = 6;
  localparam int HDR_DATA_W = 24;
  localparam int WC_W       = 16;
  localparam int DT_W       = 6;

  // Data identifiers from 0x10 upwards are long packets
  localparam logic [DT_W-1:0] LONG_DT_MIN = 6'h10;

  // Payload CRC, reflected form of x^16+x^12+x^5+1
  localparam int              CRC_W    = 16;
  localparam logic [CRC_W-1:0] CRC_POLY = 16'h8408;
  localparam logic [CRC_W-1:0] CRC_INIT = 16'hFFFF;

  // Syndrome of each header data bit, D23 first
  localparam logic [HDR_DATA_W-1:0][ECC_W-1:0] ECC_COLS = {
    6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
    6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
    6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
  };

  typedef enum logic [DT_W-1:0] {
    DT_FS    = 6'h00,
    DT_FE    = 6'h01,
    DT_LS    = 6'h02,
    DT_LE    = 6'h03,
    DT_RAW10 = 6'h2B
  } csi2_dt_e;

endpackage

`default_nettype wire

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

  // One RAW10 pixel is an MSB byte plus a 2-bit LSB field
  localparam int PX_W  = 10;
  localparam int LSB_W = 2;
  localparam int MSB_W = PX_W - LSB_W;

  // Four pixels travel in five bytes
  localparam int PX_PER_GROUP = 4;
  localparam int GROUP_BYTES  = 5;
  localparam int GROUP_W      = PX_W * PX_PER_GROUP;

  // Gearbox fill phase counts 0 to 4 buffered bytes
  localparam int PHASE_W = 3;

endpackage

`default_nettype wire

// ==== csi2_hamming_dec.sv ====
`default_nettype none

module csi2_hamming_dec (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        word_valid_i,
  input  logic [csi2_pkg::WORD_W-1:0] word_i,
  output logic                        dec_valid_o,
  output logic [csi2_pkg::WORD_W-1:0] dec_word_o,
  output logic                        dec_hdr_o,
  output logic                        hdr_err_o,
  output logic                        hdr_corr_o,
  output logic                        hdr_uncorr_o
);

logic                                 idle_q;
logic                                 is_hdr;
logic [csi2_pkg::ECC_W-1:0]           calc_ecc;
logic [csi2_pkg::ECC_W-1:0]           syndrome;
logic [csi2_pkg::HDR_DATA_W-1:0]      flip_mask;
logic                                 ecc_bit_err;
logic                                 data_bit_err;
logic                                 syn_nonzero;

// First word after an idle cycle opens a burst
assign is_hdr = word_valid_i && idle_q;

always_comb
  begin
    calc_ecc  = '0;
    flip_mask = '0;
    for (int i = 0; i < csi2_pkg::HDR_DATA_W; i++)
      if (word_i[i])
        calc_ecc = calc_ecc ^ csi2_pkg::ECC_COLS[i];
    syndrome = calc_ecc ^ word_i[csi2_pkg::HDR_DATA_W +: csi2_pkg::ECC_W];
    // A syndrome equal to a column points at one flipped data bit
    for (int i = 0; i < csi2_pkg::HDR_DATA_W; i++)
      if (syndrome == csi2_pkg::ECC_COLS[i])
        flip_mask[i] = 1'b1;
  end

assign syn_nonzero  = |syndrome;
// Single set bit means the ECC byte itself was hit
assign ecc_bit_err  = syn_nonzero && ((syndrome & (syndrome - 1'b1)) == '0);
assign data_bit_err = |flip_mask;

always_ff @(posedge clk_i or negedge rst_n_i)
  if (!rst_n_i)
    begin
      idle_q       <= 1'b1;
      dec_valid_o  <= 1'b0;
      dec_hdr_o    <= 1'b0;
      hdr_err_o    <= 1'b0;
      hdr_corr_o   <= 1'b0;
      hdr_uncorr_o <= 1'b0;
    end
  else
    begin
      idle_q       <= !word_valid_i;
      dec_valid_o  <= word_valid_i;
      dec_hdr_o    <= is_hdr;
      hdr_err_o    <= is_hdr && syn_nonzero;
      hdr_corr_o   <= is_hdr && (ecc_bit_err || data_bit_err);
      hdr_uncorr_o <= is_hdr && syn_nonzero && !ecc_bit_err && !data_bit_err;
    end

always_ff @(posedge clk_i)
  if (is_hdr)
    dec_word_o <= {word_i[csi2_pkg::WORD_W-1:csi2_pkg::HDR_DATA_W],
                   word_i[csi2_pkg::HDR_DATA_W-1:0] ^ flip_mask};
  else
    dec_word_o <= word_i;

endmodule

`default_nettype wire

// ==== csi2_pkt_parser.sv ====
`default_nettype none

module csi2_pkt_parser (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        dec_valid_i,
  input  logic [csi2_pkg::WORD_W-1:0] dec_word_i,
  input  logic                        dec_hdr_i,
  input  logic                        hdr_uncorr_i,
  output logic                        pay_valid_o,
  output logic [csi2_pkg::WORD_W-1:0] pay_data_o,
  output logic                        pay_last_o,
  output logic                        crc_rx_valid_o,
  output logic [csi2_pkg::CRC_W-1:0]  crc_rx_o,
  output logic                        frame_start_o,
  output logic                        frame_end_o
);

typedef enum logic [1:0] {
  WAIT_HDR,
  PAYLOAD,
  CRC_WORD,
  DROP
} state_e;

state_e                         state_q;
logic [csi2_pkg::WC_W-1:0]      byte_cnt_q;
csi2_pkg::csi2_dt_e             hdr_dt;
logic [csi2_pkg::WC_W-1:0]      hdr_wc;
logic                           hdr_long;
logic                           last_word;

// Header fields, lowest byte is the data identifier
assign hdr_dt    = csi2_pkg::csi2_dt_e'(dec_word_i[csi2_pkg::DT_W-1:0]);
assign hdr_wc    = dec_word_i[csi2_pkg::BYTE_W +: csi2_pkg::WC_W];
assign hdr_long  = dec_word_i[csi2_pkg::DT_W-1:0] >= csi2_pkg::LONG_DT_MIN;
assign last_word = byte_cnt_q <= csi2_pkg::WC_W'(csi2_pkg::WORD_BYTES);

always_ff @(posedge clk_i or negedge rst_n_i)
  if (!rst_n_i)
    begin
      state_q        <= WAIT_HDR;
      byte_cnt_q     <= '0;
      pay_valid_o    <= 1'b0;
      pay_last_o     <= 1'b0;
      crc_rx_valid_o <= 1'b0;
      frame_start_o  <= 1'b0;
      frame_end_o    <= 1'b0;
    end
  else
    begin
      pay_valid_o    <= 1'b0;
      pay_last_o     <= 1'b0;
      crc_rx_valid_o <= 1'b0;
      frame_start_o  <= 1'b0;
      frame_end_o    <= 1'b0;
      if (dec_valid_i && dec_hdr_i)
        begin
          // Word count is unknown, so the rest of the burst is lost
          if (hdr_uncorr_i)
            state_q <= DROP;
          else
            case (hdr_dt)
              csi2_pkg::DT_FS:
                begin
                  frame_start_o <= 1'b1;
                  state_q       <= WAIT_HDR;
                end
              csi2_pkg::DT_FE:
                begin
                  frame_end_o <= 1'b1;
                  state_q     <= WAIT_HDR;
                end
              csi2_pkg::DT_LS, csi2_pkg::DT_LE:
                state_q <= WAIT_HDR;
              csi2_pkg::DT_RAW10:
                begin
                  byte_cnt_q <= hdr_wc;
                  state_q    <= (hdr_wc == '0) ? CRC_WORD : PAYLOAD;
                end
              default:
                state_q <= hdr_long ? DROP : WAIT_HDR;
            endcase
        end
      else if (!dec_valid_i)
        // Idle cycle ends any burst
        state_q <= WAIT_HDR;
      else
        case (state_q)
          PAYLOAD:
            begin
              pay_valid_o <= 1'b1;
              pay_last_o  <= last_word;
              byte_cnt_q  <= byte_cnt_q - csi2_pkg::WC_W'(csi2_pkg::WORD_BYTES);
              if (last_word)
                state_q <= CRC_WORD;
            end
          CRC_WORD:
            begin
              crc_rx_valid_o <= 1'b1;
              state_q        <= DROP;
            end
          default:
            state_q <= DROP;
        endcase
    end

// CRC lives in the low half of its word
always_ff @(posedge clk_i)
  if (dec_valid_i)
    begin
      pay_data_o <= dec_word_i;
      crc_rx_o   <= dec_word_i[csi2_pkg::CRC_W-1:0];
    end

endmodule

`default_nettype wire

// ==== csi2_crc_calc.sv ====
`default_nettype none

module csi2_crc_calc (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        pay_valid_i,
  input  logic [csi2_pkg::WORD_W-1:0] pay_data_i,
  input  logic                        pay_last_i,
  input  logic                        crc_rx_valid_i,
  input  logic [csi2_pkg::CRC_W-1:0]  crc_rx_i,
  output logic                        crc_err_o
);

logic [csi2_pkg::CRC_W-1:0] crc_q;
logic [csi2_pkg::CRC_W-1:0] crc_hold_q;
logic [csi2_pkg::CRC_W-1:0] crc_next;

// One byte through the reflected CRC, LSB first
function automatic logic [csi2_pkg::CRC_W-1:0] crc_byte(
  input logic [csi2_pkg::CRC_W-1:0]  crc,
  input logic [csi2_pkg::BYTE_W-1:0] data
);
  logic [csi2_pkg::CRC_W-1:0] c;
  c = crc;
  for (int b = 0; b < csi2_pkg::BYTE_W; b++)
    if (c[0] ^ data[b])
      c = (c >> 1) ^ csi2_pkg::CRC_POLY;
    else
      c = c >> 1;
  return c;
endfunction

always_comb
  begin
    crc_next = crc_q;
    for (int i = 0; i < csi2_pkg::WORD_BYTES; i++)
      crc_next = crc_byte(crc_next, pay_data_i[i*csi2_pkg::BYTE_W +: csi2_pkg::BYTE_W]);
  end

always_ff @(posedge clk_i or negedge rst_n_i)
  if (!rst_n_i)
    begin
      crc_q      <= csi2_pkg::CRC_INIT;
      crc_hold_q <= csi2_pkg::CRC_INIT;
      crc_err_o  <= 1'b0;
    end
  else
    begin
      crc_err_o <= 1'b0;
      if (pay_valid_i)
        if (pay_last_i)
          begin
            // Keep the packet result until its CRC word shows up
            crc_hold_q <= crc_next;
            crc_q      <= csi2_pkg::CRC_INIT;
          end
        else
          crc_q <= crc_next;
      if (crc_rx_valid_i)
        begin
          crc_err_o  <= crc_hold_q != crc_rx_i;
          crc_hold_q <= csi2_pkg::CRC_INIT;
        end
    end

endmodule

`default_nettype wire

// ==== csi2_raw10_unpack.sv ====
`default_nettype none

module csi2_raw10_unpack (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          pay_valid_i,
  input  logic [csi2_pkg::WORD_W-1:0]   pay_data_i,
  input  logic                          pay_last_i,
  output logic                          px_valid_o,
  output logic [video_pkg::GROUP_W-1:0] px_data_o,
  output logic                          px_last_o
);

logic [video_pkg::PHASE_W-1:0]  phase_q;
logic [csi2_pkg::WORD_W-1:0]    buf_q;
logic [csi2_pkg::WORD_W-1:0]    buf_masked;
logic [2*csi2_pkg::WORD_W-1:0]  cat;
logic [2*csi2_pkg::WORD_W-1:0]  cat_rest;
logic [video_pkg::GROUP_W-1:0]  group_px;
logic                           group_done;
int                             phase_int;
int                             fill;
int                             fill_next;

always_comb
  begin
    phase_int = int'(phase_q);
    // Only the first phase_q buffered bytes are live
    for (int k = 0; k < csi2_pkg::WORD_BYTES; k++)
      if (k < phase_int)
        buf_masked[k*csi2_pkg::BYTE_W +: csi2_pkg::BYTE_W] =
          buf_q[k*csi2_pkg::BYTE_W +: csi2_pkg::BYTE_W];
      else
        buf_masked[k*csi2_pkg::BYTE_W +: csi2_pkg::BYTE_W] = '0;
    // New word lands right after the buffered bytes
    cat = ({{csi2_pkg::WORD_W{1'b0}}, pay_data_i} << (csi2_pkg::BYTE_W * phase_int)) |
          {{csi2_pkg::WORD_W{1'b0}}, buf_masked};
    cat_rest   = cat >> (video_pkg::GROUP_BYTES * csi2_pkg::BYTE_W);
    fill       = phase_int + csi2_pkg::WORD_BYTES;
    group_done = fill >= video_pkg::GROUP_BYTES;
    fill_next  = group_done ? fill - video_pkg::GROUP_BYTES : fill;
    // Pixel i is MSB byte i over LSB pair i of the fifth byte
    for (int i = 0; i < video_pkg::PX_PER_GROUP; i++)
      group_px[i*video_pkg::PX_W +: video_pkg::PX_W] = {
        cat[i*csi2_pkg::BYTE_W +: video_pkg::MSB_W],
        cat[video_pkg::PX_PER_GROUP*csi2_pkg::BYTE_W + i*video_pkg::LSB_W +: video_pkg::LSB_W]
      };
  end

always_ff @(posedge clk_i or negedge rst_n_i)
  if (!rst_n_i)
    begin
      phase_q    <= '0;
      px_valid_o <= 1'b0;
      px_last_o  <= 1'b0;
    end
  else
    begin
      px_valid_o <= pay_valid_i && group_done;
      px_last_o  <= pay_valid_i && group_done && pay_last_i;
      // Realign at the end of every line
      if (pay_valid_i)
        phase_q <= pay_last_i ? '0 : fill_next[video_pkg::PHASE_W-1:0];
    end

always_ff @(posedge clk_i)
  if (pay_valid_i)
    begin
      buf_q <= group_done ? cat_rest[csi2_pkg::WORD_W-1:0] : cat[csi2_pkg::WORD_W-1:0];
      if (group_done)
        px_data_o <= group_px;
    end

endmodule

`default_nettype wire

// ==== csi2_rx.sv ====
`default_nettype none

module csi2_rx (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          word_valid_i,
  input  logic [csi2_pkg::WORD_W-1:0]   word_i,
  output logic                          px_valid_o,
  output logic [video_pkg::GROUP_W-1:0] px_data_o,
  output logic                          px_last_o,
  output logic                          frame_start_o,
  output logic                          frame_end_o,
  output logic                          header_err_o,
  output logic                          corr_header_err_o,
  output logic                          crc_err_o
);

// Decoder to parser
logic                         dec_valid;
logic [csi2_pkg::WORD_W-1:0]  dec_word;
logic                         dec_hdr;
logic                         dec_uncorr;

// Parser to unpacker and CRC checker
logic                         pay_valid;
logic [csi2_pkg::WORD_W-1:0]  pay_data;
logic                         pay_last;
logic                         crc_rx_valid;
logic [csi2_pkg::CRC_W-1:0]   crc_rx;

csi2_hamming_dec header_corrector (
  .clk_i        ( clk_i             ),
  .rst_n_i      ( rst_n_i           ),
  .word_valid_i ( word_valid_i      ),
  .word_i       ( word_i            ),
  .dec_valid_o  ( dec_valid         ),
  .dec_word_o   ( dec_word          ),
  .dec_hdr_o    ( dec_hdr           ),
  .hdr_err_o    ( header_err_o      ),
  .hdr_corr_o   ( corr_header_err_o ),
  .hdr_uncorr_o ( dec_uncorr        )
);

// Splits packets and drops what is not RAW10 payload
csi2_pkt_parser pkt_parser (
  .clk_i          ( clk_i         ),
  .rst_n_i        ( rst_n_i       ),
  .dec_valid_i    ( dec_valid     ),
  .dec_word_i     ( dec_word      ),
  .dec_hdr_i      ( dec_hdr       ),
  .hdr_uncorr_i   ( dec_uncorr    ),
  .pay_valid_o    ( pay_valid     ),
  .pay_data_o     ( pay_data      ),
  .pay_last_o     ( pay_last      ),
  .crc_rx_valid_o ( crc_rx_valid  ),
  .crc_rx_o       ( crc_rx        ),
  .frame_start_o  ( frame_start_o ),
  .frame_end_o    ( frame_end_o   )
);

csi2_crc_calc crc_calc (
  .clk_i          ( clk_i        ),
  .rst_n_i        ( rst_n_i      ),
  .pay_valid_i    ( pay_valid    ),
  .pay_data_i     ( pay_data     ),
  .pay_last_i     ( pay_last     ),
  .crc_rx_valid_i ( crc_rx_valid ),
  .crc_rx_i       ( crc_rx       ),
  .crc_err_o      ( crc_err_o    )
);

// 32-bit words to four-pixel groups
csi2_raw10_unpack gbx (
  .clk_i       ( clk_i      ),
  .rst_n_i     ( rst_n_i    ),
  .pay_valid_i ( pay_valid  ),
  .pay_data_i  ( pay_data   ),
  .pay_last_i  ( pay_last   ),
  .px_valid_o  ( px_valid_o ),
  .px_data_o   ( px_data_o  ),
  .px_last_o   ( px_last_o  )
);

endmodule

`default_nettype wire

// ==== csi2_rx_assertions.sv ====
`default_nettype none

module csi2_rx_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic px_valid_i,
  input logic px_last_i,
  input logic frame_start_i,
  input logic frame_end_i,
  input logic header_err_i,
  input logic corr_header_err_i
);

last_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  px_last_i |-> px_valid_i)
  else $error("px_last_o high without px_valid_o");

frame_events_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  !(frame_start_i && frame_end_i))
  else $error("frame_start_o and frame_end_o high together");

// A corrected header is always an erroneous header too
corr_within_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  corr_header_err_i |-> header_err_i)
  else $error("corr_header_err_o high without header_err_o");

endmodule

bind csi2_rx csi2_rx_assertions assertions_i (
  .clk_i             ( clk_i             ),
  .rst_n_i           ( rst_n_i           ),
  .px_valid_i        ( px_valid_o        ),
  .px_last_i         ( px_last_o         ),
  .frame_start_i     ( frame_start_o     ),
  .frame_end_i       ( frame_end_o       ),
  .header_err_i      ( header_err_o      ),
  .corr_header_err_i ( corr_header_err_o )
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

localparam int HALF_PERIOD = 50;
localparam int RESET_CYCLES = 8;

initial
  begin
    clk_o = 1'b0;
    forever
      #HALF_PERIOD clk_o = ~clk_o;
  end

// Reset drops away shortly after the eighth rising edge
initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge clk_o);
    #10 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_csi2_rx.sv ====
`default_nettype none

module tb_csi2_rx;

localparam int STIM_DELAY = 10;
localparam int DRAIN_CYCLES = 8;
localparam int TIMEOUT_MARGIN = 64;

logic                          clk_i;
logic                          rst_n_i;
logic                          word_valid_i;
logic [csi2_pkg::WORD_W-1:0]   word_i;
logic                          px_valid_o;
logic [video_pkg::GROUP_W-1:0] px_data_o;
logic                          px_last_o;
logic                          frame_start_o;
logic                          frame_end_o;
logic                          header_err_o;
logic                          corr_header_err_o;
logic                          crc_err_o;

// Stimulus, one entry per clock cycle
logic                          stim_valid_q[$];
logic [csi2_pkg::WORD_W-1:0]   stim_word_q[$];

// Expected outputs, each tagged with its test name
logic [video_pkg::GROUP_W-1:0] group_q[$];
logic                          group_last_q[$];
string                         group_test_q[$];
// Frame and error events in the order they are due, by output name
string                         event_q[$];
string                         event_test_q[$];

int                            cycle_cnt;
int                            cycle_limit;

tb_clk_gen clk_gen_i (
  .clk_o   ( clk_i   ),
  .rst_n_o ( rst_n_i )
);

csi2_rx dut_i (
  .clk_i             ( clk_i             ),
  .rst_n_i           ( rst_n_i           ),
  .word_valid_i      ( word_valid_i      ),
  .word_i            ( word_i            ),
  .px_valid_o        ( px_valid_o        ),
  .px_data_o         ( px_data_o         ),
  .px_last_o         ( px_last_o         ),
  .frame_start_o     ( frame_start_o     ),
  .frame_end_o       ( frame_end_o       ),
  .header_err_o      ( header_err_o      ),
  .corr_header_err_o ( corr_header_err_o ),
  .crc_err_o         ( crc_err_o         )
);

// Reflected CRC-16, payload bits taken LSB first from byte 0 upwards
function automatic logic [csi2_pkg::CRC_W-1:0] crc_update(
  input logic [csi2_pkg::CRC_W-1:0]  crc,
  input logic [csi2_pkg::WORD_W-1:0] word
);
  logic [csi2_pkg::CRC_W-1:0] c;
  logic                       fb;
  c = crc;
  for (int n = 0; n < csi2_pkg::WORD_W; n++)
    begin
      fb = c[0] ^ word[n];
      c  = {1'b0, c[csi2_pkg::CRC_W-1:1]};
      if (fb)
        c = c ^ 16'h8408;
    end
  return c;
endfunction

task automatic report_failure(input string msg);
  $display("%s", msg);
  $display("TEST FAILED");
  $fatal(1, "run stopped");
endtask

task automatic check_group(
  input string                         test,
  input logic [video_pkg::GROUP_W-1:0] exp_data,
  input logic                          exp_last,
  input logic [video_pkg::GROUP_W-1:0] act_data,
  input logic                          act_last
);
  if (exp_data !== act_data || exp_last !== act_last)
    begin
      $display("mismatch in %s: pixel group expected %h last %0b, actual %h last %0b",
               test, exp_data, exp_last, act_data, act_last);
      $display("TEST FAILED");
      $fatal(1, "run stopped");
    end
endtask

task automatic check_event(
  input string test,
  input string name,
  input logic  exp_bit,
  input logic  act_bit
);
  if (exp_bit !== act_bit)
    begin
      $display("mismatch in %s: %s expected %0b, actual %0b", test, name, exp_bit, act_bit);
      $display("TEST FAILED");
      $fatal(1, "run stopped");
    end
endtask

// A strobe must be the next event due, otherwise it fires out of order
task automatic match_event(input string name, input logic strobe);
  string exp_name;
  string test;
  if (strobe)
    begin
      if (event_q.size() == 0)
        report_failure({"unexpected ", name, " strobe from the DUT"});
      else
        begin
          exp_name = event_q.pop_front();
          test     = event_test_q.pop_front();
          check_event(test, name, exp_name == name, strobe);
        end
    end
endtask

task automatic load_tests();
  int                          fd;
  int                          n;
  string                       line;
  string                       cmd;
  string                       arg;
  string                       cur_test;
  logic [csi2_pkg::WORD_W-1:0] w;
  logic [csi2_pkg::WORD_W-1:0] w_crc;
  logic [video_pkg::GROUP_W-1:0] g;
  int                          last;
  logic                        prev_idle;
  logic [csi2_pkg::CRC_W-1:0]  crc;
  cur_test  = "none";
  prev_idle = 1'b1;
  crc       = 16'hFFFF;
  fd = $fopen("csi2_rx_tests.txt", "r");
  if (fd == 0)
    report_failure("cannot open csi2_rx_tests.txt");
  while ($fgets(line, fd) != 0)
    begin
      n = $sscanf(line, "%s", cmd);
      if (n < 1 || cmd[0] == 8'h23)
        continue;
      if (cmd == "T")
        begin
          n = $sscanf(line, "%s %s", cmd, arg);
          cur_test = arg;
        end
      else if (cmd == "W" || cmd == "F" || cmd == "K")
        begin
          if (cmd == "K")
            w = {16'h0000, crc};
          else
            n = $sscanf(line, "%s %h %h", cmd, w, w_crc);
          if (cmd != "F")
            w_crc = w;
          // The first word of a burst is its header and stays out of the CRC
          if (prev_idle)
            crc = 16'hFFFF;
          else
            crc = crc_update(crc, w_crc);
          prev_idle = 1'b0;
          stim_valid_q.push_back(1'b1);
          stim_word_q.push_back(w);
        end
      else if (cmd == "I")
        begin
          prev_idle = 1'b1;
          stim_valid_q.push_back(1'b0);
          stim_word_q.push_back('0);
        end
      else if (cmd == "G")
        begin
          n = $sscanf(line, "%s %h %d", cmd, g, last);
          group_q.push_back(g);
          group_last_q.push_back(last != 0);
          group_test_q.push_back(cur_test);
        end
      else if (cmd == "S" || cmd == "E" || cmd == "H" || cmd == "C" || cmd == "R")
        begin
          if (cmd == "S")
            event_q.push_back("frame_start");
          else if (cmd == "E")
            event_q.push_back("frame_end");
          else if (cmd == "H")
            event_q.push_back("header_err");
          else if (cmd == "C")
            event_q.push_back("corr_header_err");
          else
            event_q.push_back("crc_err");
          event_test_q.push_back(cur_test);
        end
      else
        report_failure({"unknown command in tests file: ", cmd});
    end
  $fclose(fd);
  cycle_limit = stim_valid_q.size() + TIMEOUT_MARGIN;
endtask

// Outputs settle at the rising edge, so they are sampled on the falling one
always @(negedge clk_i)
  if (rst_n_i)
    begin
      if (px_valid_o)
        begin
          if (group_q.size() == 0)
            report_failure("unexpected pixel group from the DUT");
          else
            check_group(group_test_q.pop_front(), group_q.pop_front(),
                        group_last_q.pop_front(), px_data_o, px_last_o);
        end
      // Header error comes before its corrected flag in the expected order
      match_event("frame_start", frame_start_o);
      match_event("frame_end", frame_end_o);
      match_event("header_err", header_err_o);
      match_event("corr_header_err", corr_header_err_o);
      match_event("crc_err", crc_err_o);
    end

always @(posedge clk_i)
  if (rst_n_i)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
        begin
          $display("timeout: run did not finish within %0d cycles", cycle_limit);
          $display("TEST FAILED");
          $fatal(1, "run stopped");
        end
    end

initial
  begin
    word_valid_i = 1'b0;
    word_i       = '0;
    cycle_limit  = TIMEOUT_MARGIN;
    load_tests();
    wait (rst_n_i);
    while (stim_valid_q.size() != 0)
      begin
        @(posedge clk_i);
        #STIM_DELAY;
        word_valid_i = stim_valid_q.pop_front();
        word_i       = stim_word_q.pop_front();
      end
    @(posedge clk_i);
    #STIM_DELAY;
    word_valid_i = 1'b0;
    word_i       = '0;
    // Longest path through the chain is three cycles
    repeat (DRAIN_CYCLES)
      @(posedge clk_i);
    @(negedge clk_i);
    if (group_q.size() != 0 || event_q.size() != 0)
      begin
        $display("expected outputs never appeared: %0d groups and %0d events",
                 group_q.size(), event_q.size());
        $display("TEST FAILED");
        $fatal(1, "run stopped");
      end
    else
      begin
        $display("TEST PASSED");
        $finish;
      end
  end

endmodule

`default_nettype wire

// ==== csi2_rx_tests.txt ====
# T name | W word | F driven_word crc_word | K crc word | I idle
# G group last | S frame start | E frame end | H hdr err | C corrected | R crc err
T fs_line_fe
W 00000000
I
W 1200142B
W 04030201
W 030201E4
W 0201E404
W 01E40403
W E4040302
K
I
W 07000001
I
S
G 04C0E02404 0
G 04C0E02404 0
G 04C0E02404 0
G 04C0E02404 1
E
T hdr_single_bit
W 1200142F
W 04030201
W 030201E4
W 0201E404
W 01E40403
W E4040302
K
I
H
C
G 04C0E02404 0
G 04C0E02404 0
G 04C0E02404 0
G 04C0E02404 1
T hdr_double_bit
W 12001428
W 04030201
W 030201E4
K
I
H
T crc_corrupt
W 1200142B
F 04030205 04030201
W 030201E4
W 0201E404
W 01E40403
W E4040302
K
I
G 04C0E02414 0
G 04C0E02404 0
G 04C0E02404 0
G 04C0E02404 1
R
T realign
W 03001430
W 11111111
W 22222222
K
I
W 1B00282B
W 7F8000FF
W 8000FF1B
W 00FF1B7F
W FF1B7F80
W 1B7F8000
W 7F8000FF
W 8000FF1B
W 00FF1B7F
W FF1B7F80
W 1B7F8000
K
I
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 0
G 7F20100BFF 1

// ==== list.f ====
csi2_pkg.sv
video_pkg.sv
csi2_hamming_dec.sv
csi2_pkt_parser.sv
csi2_crc_calc.sv
csi2_raw10_unpack.sv
csi2_rx.sv
csi2_rx_assertions.sv
tb_clk_gen.sv
tb_csi2_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSI-2 receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_csi2_rx -f list.f -o tb_csi2_rx
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/tb_csi2_rx
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
